//--- logic/mpram_geom_pkg.sv
package mpram_geom_pkg;

    // Word and lane geometry
    localparam int DEF_WIDTH      = 32;
    localparam int DEF_BYTE_WIDTH = 8;   // One write strobe per lane

    // Bank layout, DEPTH is BANKS * BANK_SIZE
    localparam int DEF_BANK_SIZE  = 16;  // Rows per bank
    localparam int DEF_BANKS      = 4;

    // Port counts
    localparam int DEF_READ_PORTS  = 2;
    localparam int DEF_WRITE_PORTS = 2;

endpackage

//--- logic/mpram_ctrl_pkg.sv
package mpram_ctrl_pkg;

    // Post-reset sweep state
    typedef enum logic {
        CLEARING = 1'b0,
        RUNNING  = 1'b1
    } clear_state_t;

    // Registered read, data one edge after the strobe
    localparam int READ_LATENCY = 1;

endpackage

//--- logic/bank_router.sv
`timescale 1ns/1ps

module bank_router
    import mpram_geom_pkg::*;
    import mpram_ctrl_pkg::*;
#(
    parameter int  WIDTH       = DEF_WIDTH,
    parameter int  BANK_SIZE   = DEF_BANK_SIZE,
    parameter int  BANKS       = DEF_BANKS,
    parameter int  READ_PORTS  = DEF_READ_PORTS,
    parameter int  WRITE_PORTS = DEF_WRITE_PORTS,
    localparam int BYTES       = WIDTH / DEF_BYTE_WIDTH,
    localparam int ROW_BITS    = $clog2(BANK_SIZE),
    localparam int BANK_BITS   = $clog2(BANKS),
    localparam int ADDR_BITS   = BANK_BITS + ROW_BITS
)(
    input  logic                                              clk,
    input  logic                                              rst,
    input  logic [WRITE_PORTS-1:0][BYTES-1:0]                 wr_en,
    input  logic [WRITE_PORTS-1:0][ADDR_BITS-1:0]             wr_addr,
    input  logic [WRITE_PORTS-1:0][WIDTH-1:0]                 wr_data,
    input  logic [READ_PORTS-1:0]                             rd_en,
    input  logic [READ_PORTS-1:0][ADDR_BITS-1:0]              rd_addr,
    output logic [BANKS-1:0][WRITE_PORTS-1:0][BYTES-1:0]      bank_wr_en,
    output logic [WRITE_PORTS-1:0][ROW_BITS-1:0]              wr_row,
    output logic [WRITE_PORTS-1:0][WIDTH-1:0]                 bank_wr_data,
    output logic [BANKS-1:0][READ_PORTS-1:0]                  bank_rd_en,
    output logic [READ_PORTS-1:0][ROW_BITS-1:0]               rd_row,
    output logic                                              ready
);

    clear_state_t                               state;
    logic [ROW_BITS-1:0]                        clear_row;
    logic [WRITE_PORTS-1:0][BANK_BITS-1:0]      wr_bank;
    logic [READ_PORTS-1:0][BANK_BITS-1:0]       rd_bank;

    // Sweep one row per edge across all banks at once
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= CLEARING;
            clear_row <= '0;
            ready     <= 1'b0;
        end else if (state == CLEARING) begin
            clear_row <= clear_row + 1'b1;
            if (clear_row == ROW_BITS'(BANK_SIZE - 1)) begin // Last row goes in now
                state <= RUNNING;
                ready <= 1'b1;
            end
        end
    end

    // Bank field is the top of the address
    always_comb begin
        for (int p = 0; p < WRITE_PORTS; p++) begin
            wr_bank[p] = wr_addr[p][ADDR_BITS-1:ROW_BITS];
        end
        for (int r = 0; r < READ_PORTS; r++) begin
            rd_bank[r] = rd_addr[r][ADDR_BITS-1:ROW_BITS];
        end
    end

    always_comb begin
        for (int p = 0; p < WRITE_PORTS; p++) begin
            if (state == CLEARING) begin
                wr_row[p]       = clear_row;
                bank_wr_data[p] = '0;
            end else begin
                wr_row[p]       = wr_addr[p][ROW_BITS-1:0];
                bank_wr_data[p] = wr_data[p];
            end
            for (int b = 0; b < BANKS; b++) begin
                if (state == CLEARING) begin
                    bank_wr_en[b][p] = '1;       // User writes dropped
                end else if (wr_bank[p] == BANK_BITS'(b)) begin
                    bank_wr_en[b][p] = wr_en[p];
                end else begin
                    bank_wr_en[b][p] = '0;
                end
            end
        end
    end

    // Reads are never blocked, data during the sweep is don't-care
    always_comb begin
        for (int r = 0; r < READ_PORTS; r++) begin
            rd_row[r] = rd_addr[r][ROW_BITS-1:0];
            for (int b = 0; b < BANKS; b++) begin
                bank_rd_en[b][r] = rd_en[r] && (rd_bank[r] == BANK_BITS'(b));
            end
        end
    end

endmodule

//--- logic/ram_bank.sv
`timescale 1ns/1ps

module ram_bank
    import mpram_geom_pkg::*;
    import mpram_ctrl_pkg::*;
#(
    parameter int  WIDTH       = DEF_WIDTH,
    parameter int  BANK_SIZE   = DEF_BANK_SIZE,
    parameter int  READ_PORTS  = DEF_READ_PORTS,
    parameter int  WRITE_PORTS = DEF_WRITE_PORTS,
    localparam int BYTES       = WIDTH / DEF_BYTE_WIDTH,
    localparam int ROW_BITS    = $clog2(BANK_SIZE)
)(
    input  logic                                   clk,
    input  logic [WRITE_PORTS-1:0][BYTES-1:0]      wr_en,
    input  logic [WRITE_PORTS-1:0][ROW_BITS-1:0]   wr_row,
    input  logic [WRITE_PORTS-1:0][WIDTH-1:0]      wr_data,
    input  logic [READ_PORTS-1:0]                  rd_en,
    input  logic [READ_PORTS-1:0][ROW_BITS-1:0]    rd_row,
    output logic [READ_PORTS-1:0][WIDTH-1:0]       rd_data
);

    logic [BYTES-1:0][DEF_BYTE_WIDTH-1:0] mem [BANK_SIZE];

    if (READ_LATENCY != 1) begin : g_latency_check
        $error("ram_bank only implements a one-cycle registered read");
    end

    // Ascending port order, last assignment wins a collision
    always_ff @(posedge clk) begin
        for (int p = 0; p < WRITE_PORTS; p++) begin
            for (int k = 0; k < BYTES; k++) begin
                if (wr_en[p][k]) begin
                    mem[wr_row[p]][k] <= wr_data[p][k*DEF_BYTE_WIDTH +: DEF_BYTE_WIDTH];
                end
            end
        end
    end

    // Nonblocking sample sees the row before this edge's writes
    always_ff @(posedge clk) begin
        for (int r = 0; r < READ_PORTS; r++) begin
            if (rd_en[r]) begin
                rd_data[r] <= mem[rd_row[r]];
            end
        end
    end

endmodule

//--- logic/read_select.sv
`timescale 1ns/1ps

module read_select
    import mpram_geom_pkg::*;
    import mpram_ctrl_pkg::*;
#(
    parameter int  WIDTH      = DEF_WIDTH,
    parameter int  BANK_SIZE  = DEF_BANK_SIZE,
    parameter int  BANKS      = DEF_BANKS,
    parameter int  READ_PORTS = DEF_READ_PORTS,
    localparam int ROW_BITS   = $clog2(BANK_SIZE),
    localparam int BANK_BITS  = $clog2(BANKS),
    localparam int ADDR_BITS  = BANK_BITS + ROW_BITS
)(
    input  logic                                          clk,
    input  logic [READ_PORTS-1:0]                         rd_en,
    input  logic [READ_PORTS-1:0][ADDR_BITS-1:0]          rd_addr,
    input  logic [BANKS-1:0][READ_PORTS-1:0][WIDTH-1:0]   bank_rd_data,
    output logic [READ_PORTS-1:0][WIDTH-1:0]              rd_data
);

    logic [READ_PORTS-1:0][BANK_BITS-1:0] rd_bank_q;

    if (READ_LATENCY != 1) begin : g_latency_check
        $error("read_select delays the bank field by exactly one cycle");
    end

    // Bank of the last strobed read per port
    always_ff @(posedge clk) begin
        for (int r = 0; r < READ_PORTS; r++) begin
            if (rd_en[r]) begin
                rd_bank_q[r] <= rd_addr[r][ADDR_BITS-1:ROW_BITS];
            end
        end
    end

    // Idle port keeps pointing at a bank whose register also holds
    always_comb begin
        for (int r = 0; r < READ_PORTS; r++) begin
            rd_data[r] = bank_rd_data[rd_bank_q[r]][r];
        end
    end

endmodule

//--- logic/mpram_top.sv
`timescale 1ns/1ps

module mpram_top
    import mpram_geom_pkg::*;
#(
    parameter int  WIDTH       = DEF_WIDTH,
    parameter int  BANK_SIZE   = DEF_BANK_SIZE,
    parameter int  BANKS       = DEF_BANKS,
    parameter int  READ_PORTS  = DEF_READ_PORTS,
    parameter int  WRITE_PORTS = DEF_WRITE_PORTS,
    localparam int BYTES       = WIDTH / DEF_BYTE_WIDTH,
    localparam int ROW_BITS    = $clog2(BANK_SIZE),
    localparam int BANK_BITS   = $clog2(BANKS),
    localparam int ADDR_BITS   = BANK_BITS + ROW_BITS
)(
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic [WRITE_PORTS-1:0][BYTES-1:0]      wr_en,
    input  logic [WRITE_PORTS-1:0][ADDR_BITS-1:0]  wr_addr,
    input  logic [WRITE_PORTS-1:0][WIDTH-1:0]      wr_data,
    input  logic [READ_PORTS-1:0]                  rd_en,
    input  logic [READ_PORTS-1:0][ADDR_BITS-1:0]   rd_addr,
    output logic [READ_PORTS-1:0][WIDTH-1:0]       rd_data,
    output logic                                   ready
);

    logic [BANKS-1:0][WRITE_PORTS-1:0][BYTES-1:0]   bank_wr_en;
    logic [WRITE_PORTS-1:0][ROW_BITS-1:0]           wr_row;
    logic [WRITE_PORTS-1:0][WIDTH-1:0]              bank_wr_data;
    logic [BANKS-1:0][READ_PORTS-1:0]               bank_rd_en;
    logic [READ_PORTS-1:0][ROW_BITS-1:0]            rd_row;
    logic [BANKS-1:0][READ_PORTS-1:0][WIDTH-1:0]    bank_rd_data;

    bank_router #(
        .WIDTH       (WIDTH),
        .BANK_SIZE   (BANK_SIZE),
        .BANKS       (BANKS),
        .READ_PORTS  (READ_PORTS),
        .WRITE_PORTS (WRITE_PORTS)
    ) u_router (
        .clk, .rst,
        .wr_en, .wr_addr, .wr_data,
        .rd_en, .rd_addr,
        .bank_wr_en, .wr_row, .bank_wr_data,
        .bank_rd_en, .rd_row,
        .ready
    );

    for (genvar b = 0; b < BANKS; b++) begin : g_bank
        ram_bank #(
            .WIDTH       (WIDTH),
            .BANK_SIZE   (BANK_SIZE),
            .READ_PORTS  (READ_PORTS),
            .WRITE_PORTS (WRITE_PORTS)
        ) u_bank (
            .clk,
            .wr_en   (bank_wr_en[b]),
            .wr_row  (wr_row),                // Rows and data shared by all banks
            .wr_data (bank_wr_data),
            .rd_en   (bank_rd_en[b]),
            .rd_row  (rd_row),
            .rd_data (bank_rd_data[b])
        );
    end

    read_select #(
        .WIDTH      (WIDTH),
        .BANK_SIZE  (BANK_SIZE),
        .BANKS      (BANKS),
        .READ_PORTS (READ_PORTS)
    ) u_select (
        .clk,
        .rd_en, .rd_addr,
        .bank_rd_data,
        .rd_data
    );

endmodule

//--- verif/mpram_assertions.sv
`timescale 1ns/1ps

module mpram_assertions
    import mpram_ctrl_pkg::*;
#(
    parameter int BANKS       = 4,
    parameter int WRITE_PORTS = 2,
    parameter int BYTES       = 4
)(
    input logic                                         clk,
    input logic                                         rst,
    input clear_state_t                                 state,
    input logic                                         ready,
    input logic [BANKS-1:0][WRITE_PORTS-1:0][BYTES-1:0] bank_wr_en
);

    int fail_count = 0;     // Read back by the testbench at the end

    a_ready_low_clearing: assert property (@(posedge clk) (state == CLEARING) |-> !ready)
        else begin
            fail_count++;
            $error("ready is high while the clear sweep is running");
        end

    // Sticky once the sweep is done
    a_ready_sticky: assert property (@(posedge clk) disable iff (rst) ready |=> ready)
        else begin
            fail_count++;
            $error("ready fell without a reset");
        end

    a_clear_strobes: assert property (@(posedge clk) (state == CLEARING) |-> (bank_wr_en == '1))
        else begin
            fail_count++;
            $error("bank write strobes not all set during the clear sweep");
        end

endmodule

bind bank_router mpram_assertions #(
    .BANKS       (BANKS),
    .WRITE_PORTS (WRITE_PORTS),
    .BYTES       (BYTES)
) u_assert (
    .clk        (clk),
    .rst        (rst),
    .state      (state),
    .ready      (ready),
    .bank_wr_en (bank_wr_en)
);

//--- verif/mpram_tb.sv
`timescale 1ns/1ps

module mpram_tb
    import mpram_geom_pkg::*;
;

    localparam int WIDTH       = DEF_WIDTH;
    localparam int BYTE_W      = DEF_BYTE_WIDTH;
    localparam int BYTES       = DEF_WIDTH / DEF_BYTE_WIDTH;
    localparam int BANK_SIZE   = DEF_BANK_SIZE;
    localparam int BANKS       = DEF_BANKS;
    localparam int READ_PORTS  = DEF_READ_PORTS;
    localparam int WRITE_PORTS = DEF_WRITE_PORTS;
    localparam int ADDR_BITS   = $clog2(BANKS) + $clog2(BANK_SIZE);
    localparam int DEPTH       = BANKS * BANK_SIZE;
    localparam int READY_TIMEOUT = 200;     // Cycles
    localparam int WATCHDOG_NS   = 200_000;

    logic                                  clk;
    logic                                  rst;
    logic [WRITE_PORTS-1:0][BYTES-1:0]     wr_en;
    logic [WRITE_PORTS-1:0][ADDR_BITS-1:0] wr_addr;
    logic [WRITE_PORTS-1:0][WIDTH-1:0]     wr_data;
    logic [READ_PORTS-1:0]                 rd_en;
    logic [READ_PORTS-1:0][ADDR_BITS-1:0]  rd_addr;
    logic [READ_PORTS-1:0][WIDTH-1:0]      rd_data;
    logic                                  ready;

    logic [WIDTH-1:0] model [DEPTH];       // Reference memory, flat address
    logic [WIDTH-1:0] exp_rd [READ_PORTS]; // Last strobed read per port
    bit   [READ_PORTS-1:0] exp_valid;
    int   value_errors;
    int   timeout_errors;

    mpram_top DUT (
        .clk, .rst,
        .wr_en, .wr_addr, .wr_data,
        .rd_en, .rd_addr,
        .rd_data, .ready
    );

    always #10 clk = ~clk;

    task automatic check_value(input string name, input int port,
                               input logic [WIDTH-1:0] expected, input logic [WIDTH-1:0] actual);
        assert (actual === expected) else begin
            value_errors++;
            $display("** Error [%s] port %0d: expected %h, actual %h",
                     name, port, expected, actual);
        end
    endtask

    task automatic clear_strobes();
        wr_en = '0;
        rd_en = '0;
    endtask

    task automatic zero_model();
        for (int i = 0; i < DEPTH; i++) begin
            model[i] = '0;                      // Clear sweep leaves zeros
        end
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
        end
        #2;
        rst = 1'b0;
    endtask

    // Clocks the current inputs and updates the model read-first
    task automatic step(input string name);
        for (int r = 0; r < READ_PORTS; r++) begin
            if (rd_en[r]) begin
                exp_rd[r]    = model[rd_addr[r]];
                exp_valid[r] = 1'b1;
            end
        end
        for (int p = 0; p < WRITE_PORTS; p++) begin   // Ascending, high port wins
            for (int k = 0; k < BYTES; k++) begin
                if (wr_en[p][k]) begin
                    model[wr_addr[p]][k*BYTE_W +: BYTE_W] = wr_data[p][k*BYTE_W +: BYTE_W];
                end
            end
        end
        @(posedge clk);
        #1;
        for (int r = 0; r < READ_PORTS; r++) begin
            if (exp_valid[r]) begin
                check_value(name, r, exp_rd[r], rd_data[r]);
            end
        end
        #1;
    endtask

    task automatic wait_ready(output bit ok);
        int n;
        n = 0;
        while (!ready && n < READY_TIMEOUT) begin
            @(posedge clk);
            #2;
            n++;
        end
        ok = ready;
        assert (ok) else begin
            timeout_errors++;
            $display("Timeout: ready did not rise within %0d cycles after reset", READY_TIMEOUT);
        end
    endtask

    task automatic drive_random(input bit full_words, input int rd_odds);
        for (int p = 0; p < WRITE_PORTS; p++) begin
            if (full_words) begin
                wr_en[p] = ($urandom_range(0, 1) == 1) ? '1 : '0;
            end else begin
                wr_en[p] = BYTES'($urandom);
            end
            wr_addr[p] = ADDR_BITS'($urandom_range(0, DEPTH - 1));
            wr_data[p] = WIDTH'($urandom);
        end
        for (int r = 0; r < READ_PORTS; r++) begin
            rd_en[r]   = ($urandom_range(0, rd_odds - 1) == 0);
            rd_addr[r] = ADDR_BITS'($urandom_range(0, DEPTH - 1));
        end
    endtask

    // Read ports offset so each edge hits different banks
    task automatic read_sweep(input string name);
        clear_strobes();
        for (int a = 0; a < DEPTH; a++) begin
            rd_en = '1;
            for (int r = 0; r < READ_PORTS; r++) begin
                rd_addr[r] = ADDR_BITS'(a + r * 17);
            end
            step(name);
        end
        clear_strobes();
    endtask

    task automatic collision_test(input int trials);
        logic [ADDR_BITS-1:0] a;
        logic [WIDTH-1:0]     old_word;
        logic [WIDTH-1:0]     d0;
        logic [WIDTH-1:0]     merged;
        logic [BYTES-1:0]     m0;
        logic [BYTES-1:0]     m1;
        int                   lane;
        for (int t = 0; t < trials; t++) begin
            a        = ADDR_BITS'($urandom_range(0, DEPTH - 1));
            old_word = model[a];
            lane     = $urandom_range(0, BYTES - 1);
            m0       = BYTES'($urandom) | BYTES'(1 << lane);  // Shared lane forces overlap
            m1       = BYTES'($urandom) | BYTES'(1 << lane);
            d0       = WIDTH'($urandom);
            clear_strobes();
            wr_en[0]   = m0;
            wr_en[1]   = m1;
            wr_addr[0] = a;
            wr_addr[1] = a;
            wr_data[0] = d0;
            wr_data[1] = ~d0;
            step("collision_write");
            clear_strobes();
            rd_en[0]   = 1'b1;
            rd_addr[0] = a;
            step("collision_read");
            for (int k = 0; k < BYTES; k++) begin
                if (m1[k]) begin
                    merged[k*BYTE_W +: BYTE_W] = ~d0[k*BYTE_W +: BYTE_W];
                end else if (m0[k]) begin
                    merged[k*BYTE_W +: BYTE_W] = d0[k*BYTE_W +: BYTE_W];
                end else begin
                    merged[k*BYTE_W +: BYTE_W] = old_word[k*BYTE_W +: BYTE_W];
                end
            end
            check_value("collision_merge", 0, merged, rd_data[0]);
        end
        clear_strobes();
    endtask

    task automatic read_during_write_test(input int trials);
        logic [ADDR_BITS-1:0] a;
        logic [WIDTH-1:0]     old_word;
        logic [WIDTH-1:0]     d;
        int                   wp;
        int                   rp;
        for (int t = 0; t < trials; t++) begin
            a        = ADDR_BITS'($urandom_range(0, DEPTH - 1));
            old_word = model[a];
            d        = WIDTH'($urandom);
            wp       = t % WRITE_PORTS;
            rp       = (t / 2) % READ_PORTS;
            clear_strobes();
            wr_en[wp]   = '1;
            wr_addr[wp] = a;
            wr_data[wp] = d;
            rd_en[rp]   = 1'b1;
            rd_addr[rp] = a;
            step("rdw_same_edge");
            check_value("rdw_old", rp, old_word, rd_data[rp]);
            clear_strobes();
            rd_en[rp]   = 1'b1;
            rd_addr[rp] = a;
            step("rdw_next_edge");
            check_value("rdw_new", rp, d, rd_data[rp]);
        end
        clear_strobes();
    endtask

    // Hard stop if anything stalls
    initial begin
        #(WATCHDOG_NS);
        $display("Simulation ran past %0d ns without finishing", WATCHDOG_NS);
        $display("Errors found");
        $finish;
    end

    initial begin
        bit ok;
        int total;
        clk            = 1'b0;
        rst            = 1'b1;
        wr_en          = '0;
        wr_addr        = '0;
        wr_data        = '0;
        rd_en          = '0;
        rd_addr        = '0;
        exp_valid      = '0;
        value_errors   = 0;
        timeout_errors = 0;
        void'($urandom(32'h6aa2_c878));
        zero_model();
        apply_reset();

        wait_ready(ok);
        if (ok) begin
            read_sweep("clear");
            for (int i = 0; i < 400; i++) begin
                drive_random(1'b1, 2);
                step("random_full");
            end
            for (int i = 0; i < 200; i++) begin
                drive_random(1'b0, 2);
                step("byte_enable");
            end
            read_sweep("byte_enable_sweep");
            collision_test(20);
            read_during_write_test(20);
            for (int i = 0; i < 200; i++) begin
                drive_random(1'b0, 6);          // Mostly idle read ports
                step("hold");
            end
            clear_strobes();

            // Reset over written contents so the sweep has rows to zero
            zero_model();
            apply_reset();
            wait_ready(ok);
            if (ok) begin
                read_sweep("clear_after_traffic");
            end
        end

        total = value_errors + timeout_errors + DUT.u_router.u_assert.fail_count;
        $display("Checks done: %0d value errors, %0d timeout errors, %0d assertion failures",
                 value_errors, timeout_errors, DUT.u_router.u_assert.fail_count);
        if (total == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- mpram_top.f
logic/mpram_geom_pkg.sv
logic/mpram_ctrl_pkg.sv
logic/bank_router.sv
logic/ram_bank.sv
logic/read_select.sv
logic/mpram_top.sv
verif/mpram_assertions.sv
verif/mpram_tb.sv

//--- Makefile
# Verilator build and run of the banked multi-port RAM testbench

TOP             ?= mpram_tb
FILELIST        ?= mpram_top.f
LOG             ?= sim.log
FAIL_MSG        ?= Errors found
OBJ_DIR         ?= obj_dir
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --assert --timing -j 0
SIM_FLAGS       ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(SIM_FLAGS) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
